// File: source/tcdm_settings.svh
// Group-wide sizing macros
// Tile count, bank depth and word width

`ifndef TCDM_SETTINGS_SVH
`define TCDM_SETTINGS_SVH

// Tiles in the group, one bank each
`define TCDM_NUM_TILES 4

// Words per bank
`define TCDM_BANK_ROWS 64

// Word width in bits
`define TCDM_DATA_WIDTH 32

`endif

// File: source/tcdm_pkg.sv
// Shared types of the tile-to-bank interconnect
// Address, index, row, data and byte-enable types
`default_nettype none

`include "tcdm_settings.svh"

package tcdm_pkg;

  // Tile or bank index
  typedef logic [$clog2(`TCDM_NUM_TILES)-1:0] tile_idx_t;

  // Row inside one bank
  typedef logic [$clog2(`TCDM_BANK_ROWS)-1:0] row_t;

  // One data word and its byte enables
  typedef logic [`TCDM_DATA_WIDTH-1:0] data_t;
  typedef logic [`TCDM_DATA_WIDTH/8-1:0] strb_t;

  // Byte address with row, tile and byte offset from high to low
  typedef logic [$clog2(`TCDM_DATA_WIDTH/8) + $bits(tile_idx_t) + $bits(row_t)-1:0]
    tcdm_addr_t;

endpackage

`default_nettype wire

// File: source/tcdm_req_if.sv
// Request bundle into one bank from all tiles
// Decoder and bank modports
`default_nettype none

`include "tcdm_settings.svh"

interface tcdm_req_if;

  // One entry per initiating tile
  logic            [`TCDM_NUM_TILES-1:0] valid;
  logic            [`TCDM_NUM_TILES-1:0] ready;
  tcdm_pkg::row_t  [`TCDM_NUM_TILES-1:0] row;
  logic            [`TCDM_NUM_TILES-1:0] wen;
  tcdm_pkg::data_t [`TCDM_NUM_TILES-1:0] wdata;
  tcdm_pkg::strb_t [`TCDM_NUM_TILES-1:0] be;

  modport decoder (
    output valid, row, wen, wdata, be,
    input  ready
  );

  modport bank (
    input  valid, row, wen, wdata, be,
    output ready
  );

endinterface

`default_nettype wire

// File: source/tcdm_resp_if.sv
// Response bundle from one bank toward the tiles
// Bank and router modports
`default_nettype none

interface tcdm_resp_if;

  logic                valid;
  logic                ready;
  tcdm_pkg::tile_idx_t ini;
  tcdm_pkg::data_t     rdata;

  modport bank (
    output valid, ini, rdata,
    input  ready
  );

  modport router (
    input  valid, ini, rdata,
    output ready
  );

endinterface

`default_nettype wire

// File: source/tcdm_addr_decode.sv
// Address decoder steering tile requests to banks
// Returns the target bank's ready to each tile
`default_nettype none

`include "tcdm_settings.svh"

module tcdm_addr_decode (
  input  logic                 [`TCDM_NUM_TILES-1:0] req_valid_i,
  output logic                 [`TCDM_NUM_TILES-1:0] req_ready_o,
  input  tcdm_pkg::tcdm_addr_t [`TCDM_NUM_TILES-1:0] req_addr_i,
  input  logic                 [`TCDM_NUM_TILES-1:0] req_wen_i,
  input  tcdm_pkg::data_t      [`TCDM_NUM_TILES-1:0] req_wdata_i,
  input  tcdm_pkg::strb_t      [`TCDM_NUM_TILES-1:0] req_be_i,
  tcdm_req_if.decoder                                bank_req [`TCDM_NUM_TILES-1:0]
);

  localparam int unsigned OffBits  = $clog2($bits(tcdm_pkg::strb_t));
  localparam int unsigned TileBits = $bits(tcdm_pkg::tile_idx_t);
  localparam int unsigned RowBits  = $bits(tcdm_pkg::row_t);

  tcdm_pkg::tile_idx_t [`TCDM_NUM_TILES-1:0] tile_tgt;
  tcdm_pkg::row_t      [`TCDM_NUM_TILES-1:0] tile_row;
  logic                [`TCDM_NUM_TILES-1:0] bank_valid [`TCDM_NUM_TILES];
  logic                [`TCDM_NUM_TILES-1:0] bank_ready [`TCDM_NUM_TILES];

  // Word interleaving puts the bank in the low word bits
  always_comb begin
    for (int t = 0; t < `TCDM_NUM_TILES; t++) begin
      tile_tgt[t] = req_addr_i[t][OffBits +: TileBits];
      tile_row[t] = req_addr_i[t][OffBits + TileBits +: RowBits];
    end
  end

  always_comb begin
    for (int b = 0; b < `TCDM_NUM_TILES; b++) begin
      bank_valid[b] = '0;
    end
    for (int t = 0; t < `TCDM_NUM_TILES; t++) begin
      bank_valid[tile_tgt[t]][t] = req_valid_i[t];
      req_ready_o[t]             = bank_ready[tile_tgt[t]][t];
    end
  end

  for (genvar b = 0; b < `TCDM_NUM_TILES; b++) begin : gen_bank_req
    assign bank_req[b].valid = bank_valid[b];
    assign bank_req[b].row   = tile_row;
    assign bank_req[b].wen   = req_wen_i;
    assign bank_req[b].wdata = req_wdata_i;
    assign bank_req[b].be    = req_be_i;
    assign bank_ready[b]     = bank_req[b].ready;
  end

endmodule

`default_nettype wire

// File: source/tcdm_bank.sv
// Memory bank with round-robin arbitration among tiles
// Byte-enabled writes, registered read response slot
`default_nettype none

`include "tcdm_settings.svh"

module tcdm_bank (
  input  logic      clk_i,
  input  logic      rst_n_i,
  tcdm_req_if.bank  req,
  tcdm_resp_if.bank resp
);

  localparam int unsigned NumBytes = $bits(tcdm_pkg::strb_t);

  tcdm_pkg::data_t     mem_q [`TCDM_BANK_ROWS];
  tcdm_pkg::tile_idx_t rr_q;
  tcdm_pkg::tile_idx_t gnt_idx;
  logic                gnt_found;
  logic                grant;
  tcdm_pkg::row_t      gnt_row;
  logic                gnt_wen;
  logic                slot_valid_q;
  tcdm_pkg::tile_idx_t slot_ini_q;
  tcdm_pkg::data_t     slot_rdata_q;

  // First requester at or after the pointer
  always_comb begin
    tcdm_pkg::tile_idx_t idx;
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    for (int off = 0; off < `TCDM_NUM_TILES; off++) begin
      idx = rr_q + tcdm_pkg::tile_idx_t'(off);
      if (!gnt_found && req.valid[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = idx;
      end
    end
  end

  // Stall while the slot holds an undrained response
  assign grant   = gnt_found && (!slot_valid_q || resp.ready);
  assign gnt_row = req.row[gnt_idx];
  assign gnt_wen = req.wen[gnt_idx];

  always_comb begin
    req.ready = '0;
    if (grant) begin
      req.ready[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant && gnt_wen) begin
      for (int i = 0; i < NumBytes; i++) begin
        if (req.be[gnt_idx][i]) begin
          mem_q[gnt_row][8*i +: 8] <= req.wdata[gnt_idx][8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant && !gnt_wen) begin
      slot_ini_q   <= gnt_idx;
      slot_rdata_q <= mem_q[gnt_row];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q         <= '0;
      slot_valid_q <= 1'b0;
    end else begin
      if (grant) begin
        rr_q <= gnt_idx + 1'b1;
      end
      // Writes leave the slot alone
      if (grant && !gnt_wen) begin
        slot_valid_q <= 1'b1;
      end else if (resp.ready) begin
        slot_valid_q <= 1'b0;
      end
    end
  end

  assign resp.valid = slot_valid_q;
  assign resp.ini   = slot_ini_q;
  assign resp.rdata = slot_rdata_q;

endmodule

`default_nettype wire

// File: source/tcdm_resp_router.sv
// Response router from banks back to initiating tiles
// Per-tile round-robin over banks with pending responses
`default_nettype none

`include "tcdm_settings.svh"

module tcdm_resp_router (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  tcdm_resp_if.router                           bank_resp [`TCDM_NUM_TILES-1:0],
  output logic            [`TCDM_NUM_TILES-1:0] resp_valid_o,
  input  logic            [`TCDM_NUM_TILES-1:0] resp_ready_i,
  output tcdm_pkg::data_t [`TCDM_NUM_TILES-1:0] resp_rdata_o
);

  logic                b_valid [`TCDM_NUM_TILES];
  tcdm_pkg::tile_idx_t b_ini   [`TCDM_NUM_TILES];
  tcdm_pkg::data_t     b_rdata [`TCDM_NUM_TILES];
  logic                b_ready [`TCDM_NUM_TILES];
  tcdm_pkg::tile_idx_t rr_q    [`TCDM_NUM_TILES];
  tcdm_pkg::tile_idx_t sel     [`TCDM_NUM_TILES];
  logic                sel_valid [`TCDM_NUM_TILES];

  for (genvar b = 0; b < `TCDM_NUM_TILES; b++) begin : gen_bank_resp
    assign b_valid[b]           = bank_resp[b].valid;
    assign b_ini[b]             = bank_resp[b].ini;
    assign b_rdata[b]           = bank_resp[b].rdata;
    assign bank_resp[b].ready   = b_ready[b];
  end

  // Each bank names one tile, so grants never collide
  always_comb begin
    tcdm_pkg::tile_idx_t idx;
    for (int b = 0; b < `TCDM_NUM_TILES; b++) begin
      b_ready[b] = 1'b0;
    end
    for (int t = 0; t < `TCDM_NUM_TILES; t++) begin
      sel_valid[t] = 1'b0;
      sel[t]       = rr_q[t];
      for (int off = 0; off < `TCDM_NUM_TILES; off++) begin
        idx = rr_q[t] + tcdm_pkg::tile_idx_t'(off);
        if (!sel_valid[t] && b_valid[idx] && b_ini[idx] == tcdm_pkg::tile_idx_t'(t)) begin
          sel_valid[t] = 1'b1;
          sel[t]       = idx;
        end
      end
      resp_valid_o[t] = sel_valid[t];
      resp_rdata_o[t] = b_rdata[sel[t]];
      if (sel_valid[t] && resp_ready_i[t]) begin
        b_ready[sel[t]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int t = 0; t < `TCDM_NUM_TILES; t++) begin
        rr_q[t] <= '0;
      end
    end else begin
      for (int t = 0; t < `TCDM_NUM_TILES; t++) begin
        if (sel_valid[t] && resp_ready_i[t]) begin
          rr_q[t] <= sel[t] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/tcdm_group.sv
// Group top level with plain per-tile request and response ports
// Address decoder, one bank per tile and the response router
`default_nettype none

`include "tcdm_settings.svh"

module tcdm_group (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  // Tile requests
  input  logic                 [`TCDM_NUM_TILES-1:0] req_valid_i,
  output logic                 [`TCDM_NUM_TILES-1:0] req_ready_o,
  input  tcdm_pkg::tcdm_addr_t [`TCDM_NUM_TILES-1:0] req_addr_i,
  input  logic                 [`TCDM_NUM_TILES-1:0] req_wen_i,
  input  tcdm_pkg::data_t      [`TCDM_NUM_TILES-1:0] req_wdata_i,
  input  tcdm_pkg::strb_t      [`TCDM_NUM_TILES-1:0] req_be_i,
  // Read responses
  output logic                 [`TCDM_NUM_TILES-1:0] resp_valid_o,
  input  logic                 [`TCDM_NUM_TILES-1:0] resp_ready_i,
  output tcdm_pkg::data_t      [`TCDM_NUM_TILES-1:0] resp_rdata_o
);

  // One request and one response bundle per bank
  tcdm_req_if  req_if  [`TCDM_NUM_TILES-1:0] ();
  tcdm_resp_if resp_if [`TCDM_NUM_TILES-1:0] ();

  tcdm_addr_decode i_addr_decode (
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i ),
    .req_wen_i   (req_wen_i  ),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i   ),
    .bank_req    (req_if     )
  );

  for (genvar b = 0; b < `TCDM_NUM_TILES; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i   (clk_i     ),
      .rst_n_i (rst_n_i   ),
      .req     (req_if[b] ),
      .resp    (resp_if[b])
    );
  end

  tcdm_resp_router i_resp_router (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .bank_resp    (resp_if     ),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_tcdm_group.sv
// Directed testbench for the tile-to-bank group
// Reference memory model, value checker and watchdog
`default_nettype none

`include "tcdm_settings.svh"

module tb_tcdm_group;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTiles   = `TCDM_NUM_TILES;
  localparam int NumTests   = 6;
  localparam int WatchdogNs = NumTests * 2000 + 200;
  localparam int MaxWait    = 50;

  logic                                 clk_i;
  logic                                 rst_n_i;
  logic                 [NumTiles-1:0]  req_valid_i;
  logic                 [NumTiles-1:0]  req_ready_o;
  tcdm_pkg::tcdm_addr_t [NumTiles-1:0]  req_addr_i;
  logic                 [NumTiles-1:0]  req_wen_i;
  tcdm_pkg::data_t      [NumTiles-1:0]  req_wdata_i;
  tcdm_pkg::strb_t      [NumTiles-1:0]  req_be_i;
  logic                 [NumTiles-1:0]  resp_valid_o;
  logic                 [NumTiles-1:0]  resp_ready_i;
  tcdm_pkg::data_t      [NumTiles-1:0]  resp_rdata_o;

  // Word address to stored data
  tcdm_pkg::data_t ref_mem [int];
  int              errors;
  int              checks;

  tcdm_group tcdm_group_inst (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_addr_i   (req_addr_i  ),
    .req_wen_i    (req_wen_i   ),
    .req_wdata_i  (req_wdata_i ),
    .req_be_i     (req_be_i    ),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
    end
  endtask

  // Row in the upper bits, bank in the low word bits
  function automatic tcdm_pkg::tcdm_addr_t make_addr(input int row, input int bank);
    return {tcdm_pkg::row_t'(row), tcdm_pkg::tile_idx_t'(bank), 2'b00};
  endfunction

  function automatic tcdm_pkg::data_t merge_bytes(input tcdm_pkg::data_t old_word,
                                                  input tcdm_pkg::data_t new_word,
                                                  input tcdm_pkg::strb_t be);
    tcdm_pkg::data_t res;
    res = old_word;
    for (int i = 0; i < $bits(be); i++) begin
      if (be[i]) res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

  // Called and returning 1 ns after a rising edge
  task automatic issue_request(input int tile, input tcdm_pkg::tcdm_addr_t addr,
                               input logic wen, input tcdm_pkg::data_t wdata,
                               input tcdm_pkg::strb_t be);
    logic accepted;
    accepted          = 1'b0;
    req_valid_i[tile] = 1'b1;
    req_addr_i[tile]  = addr;
    req_wen_i[tile]   = wen;
    req_wdata_i[tile] = wdata;
    req_be_i[tile]    = be;
    for (int c = 0; c < MaxWait && !accepted; c++) begin
      @(negedge clk_i);
      accepted = req_ready_o[tile];
      @(posedge clk_i);
      #1;
    end
    req_valid_i[tile] = 1'b0;
    if (!accepted) begin
      errors++;
      $display("Tile %0d request to 0x%03h was never accepted", tile, addr);
    end
  endtask

  task automatic wait_response(input int tile, output tcdm_pkg::data_t rdata);
    logic taken;
    taken = 1'b0;
    rdata = 'x;
    for (int c = 0; c < MaxWait && !taken; c++) begin
      @(negedge clk_i);
      if (resp_valid_o[tile] && resp_ready_i[tile]) begin
        taken = 1'b1;
        rdata = resp_rdata_o[tile];
      end
      @(posedge clk_i);
      #1;
    end
    if (!taken) begin
      errors++;
      $display("Tile %0d received no read response", tile);
    end
  endtask

  task automatic write_word(input int tile, input tcdm_pkg::tcdm_addr_t addr,
                            input tcdm_pkg::data_t wdata, input tcdm_pkg::strb_t be);
    tcdm_pkg::data_t old_word;
    old_word = ref_mem.exists(addr >> 2) ? ref_mem[addr >> 2] : 'x;
    issue_request(tile, addr, 1'b1, wdata, be);
    ref_mem[addr >> 2] = merge_bytes(old_word, wdata, be);
  endtask

  task automatic read_check(input int tile, input tcdm_pkg::tcdm_addr_t addr);
    tcdm_pkg::data_t rdata;
    issue_request(tile, addr, 1'b0, '0, '0);
    wait_response(tile, rdata);
    check_value($sformatf("resp_rdata_o[%0d]", tile), ref_mem[addr >> 2], rdata);
  endtask

  task automatic reset_state();
    repeat (10) begin
      @(negedge clk_i);
      check_value("resp_valid_o", '0, resp_valid_o);
    end
    @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("resp_valid_o", '0, resp_valid_o);
    @(posedge clk_i);
    #1;
  endtask

  task automatic all_banks_roundtrip();
    for (int t = 0; t < NumTiles; t++) begin
      for (int b = 0; b < NumTiles; b++) begin
        write_word(t, make_addr(8 * t + b, b), $urandom, 4'hf);
      end
      for (int b = 0; b < NumTiles; b++) begin
        read_check(t, make_addr(8 * t + b, b));
      end
    end
  endtask

  task automatic partial_byte_write();
    write_word(1, make_addr(33, 2), $urandom, 4'hf);
    write_word(1, make_addr(33, 2), $urandom, 4'b0101);
    read_check(1, make_addr(33, 2));
  endtask

  task automatic cross_tile_read();
    write_word(0, make_addr(50, 1), $urandom, 4'hf);
    read_check(3, make_addr(50, 1));
  endtask

  // All tiles hit bank 1 in the same cycle
  task automatic same_bank_contention();
    for (int t = 0; t < NumTiles; t++) begin
      write_word(0, make_addr(40 + t, 1), $urandom, 4'hf);
    end
    fork
      read_check(0, make_addr(40, 1));
      read_check(1, make_addr(41, 1));
      read_check(2, make_addr(42, 1));
      read_check(3, make_addr(43, 1));
    join
  endtask

  task automatic held_response();
    tcdm_pkg::data_t held;
    write_word(2, make_addr(20, 2), $urandom, 4'hf);
    resp_ready_i[2] = 1'b0;
    issue_request(2, make_addr(20, 2), 1'b0, '0, '0);
    @(negedge clk_i);
    check_value("resp_valid_o[2]", 1'b1, resp_valid_o[2]);
    held = resp_rdata_o[2];
    repeat (5) begin
      @(negedge clk_i);
      check_value("resp_valid_o[2]", 1'b1, resp_valid_o[2]);
      check_value("resp_rdata_o[2]", held, resp_rdata_o[2]);
    end
    @(posedge clk_i);
    #1;
    resp_ready_i[2] = 1'b1;
    @(negedge clk_i);
    check_value("resp_rdata_o[2]", ref_mem[make_addr(20, 2) >> 2], resp_rdata_o[2]);
    @(posedge clk_i);
    #1;
    @(negedge clk_i);
    check_value("resp_valid_o[2]", 1'b0, resp_valid_o[2]);
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    #WatchdogNs;
    $display("Tests timed out after %0d ns", WatchdogNs);
    $display("Regression failed");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = '0;
    req_addr_i   = '0;
    req_wen_i    = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = '1;
    errors       = 0;
    checks       = 0;
    void'($urandom(32'hee5e5857));
    reset_state();
    all_banks_roundtrip();
    partial_byte_write();
    cross_tile_read();
    same_bank_contention();
    held_response();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/tcdm_pkg.sv
source/tcdm_req_if.sv
source/tcdm_resp_if.sv
source/tcdm_addr_decode.sv
source/tcdm_bank.sv
source/tcdm_resp_router.sv
source/tcdm_group.sv
tb/tb_tcdm_group.sv
